//--- source/rvIsaPkg.sv
// RV32I encodings for the next-PC path: instruction classes, branch funct3 codes, flag layout
`default_nettype none

package rvIsaPkg;

    // instruction class as produced by decode
    typedef enum logic [3:0] {
        classLoad   = 4'd0,
        classImm    = 4'd1,
        classStore  = 4'd2,
        classReg    = 4'd3,
        classLui    = 4'd4,
        classAuipc  = 4'd5,
        classBranch = 4'd6,
        classJalr   = 4'd7,
        classJal    = 4'd8
    } instClassT;

    // funct3 field of the branch opcode, 2 and 3 are unused
    typedef enum logic [2:0] {
        branchBeq  = 3'd0,
        branchBne  = 3'd1,
        branchBlt  = 3'd4,
        branchBge  = 3'd5,
        branchBltu = 3'd6,
        branchBgeu = 3'd7
    } branchFunctT;

    // condition flags, zero in the top bit down to overflow
    typedef logic [3:0] flagsT;

    localparam int flagZero     = 3;
    localparam int flagCarry    = 2; // borrow, set when rs1 < rs2 unsigned
    localparam int flagNegative = 1;
    localparam int flagOverflow = 0;

endpackage

`default_nettype wire

//--- source/pcPathPkg.sv
// datapath word types and the structs handed from one PC pipeline stage to the next
`default_nettype none

package pcPathPkg;

    import rvIsaPkg::*;

    localparam int wordWidth = 32;

    typedef logic [wordWidth-1:0] wordT;
    typedef logic [2:0]           funct3T;

    localparam wordT wordBytes = wordT'(4); // sequential step, no compressed instructions

    // request presented with inValid
    typedef struct packed {
        instClassT instClass;
        funct3T    funct3;
        wordT      imm;
        wordT      rs1Value;
        wordT      rs2Value;
        wordT      pc;
    } pcRequestT;

    // stage one to stage two, rs2 is consumed by the flag compare
    typedef struct packed {
        instClassT instClass;
        funct3T    funct3;
        wordT      imm;
        wordT      rs1Value;
        wordT      pc;
        flagsT     flags;
    } flaggedT;

    // stage two to stage three
    typedef struct packed {
        wordT base;
        wordT offset;
        logic redirect; // target is not pc + 4
    } operandPairT;

    typedef struct packed {
        wordT nextPc;
        logic redirect;
    } pcResultT;

endpackage

`default_nettype wire

//--- source/rippleCarryAdderSubtractor.sv
// ripple-carry adder/subtractor, a chain of full-adder cells with signed overflow detect
`default_nettype none

module rippleCarryAdderSubtractor #(
    parameter int width = 32
) (
    input  logic [width-1:0] a,
    input  logic [width-1:0] b,
    input  logic             subtract,
    output logic [width-1:0] sum,
    output logic             carryOut,
    output logic             overflow
);

    logic [width:0]   carry;
    logic [width-1:0] bOperand;

    // two's complement subtract: invert b and carry in a one
    assign bOperand = b ^ {width{subtract}};
    assign carry[0] = subtract;

    for (genvar bitIdx = 0; bitIdx < width; bitIdx++) begin : gCell
        logic halfSum;

        assign halfSum           = a[bitIdx] ^ bOperand[bitIdx];
        assign sum[bitIdx]       = halfSum ^ carry[bitIdx];
        assign carry[bitIdx + 1] = (a[bitIdx] & bOperand[bitIdx]) | (carry[bitIdx] & halfSum);
    end

    assign carryOut = carry[width];
    assign overflow = carry[width] ^ carry[width-1]; // carry into and out of the sign bit differ

endmodule

`default_nettype wire

//--- source/flagCompareStage.sv
// stage one: subtract rs2 from rs1 and register the ZCNV flags with the instruction fields
`default_nettype none

module flagCompareStage
    import rvIsaPkg::*;
    import pcPathPkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      inValid,
    input  pcRequestT request,
    output logic      flaggedValid,
    output flaggedT   flagged
);

    wordT    difference;
    logic    carryOut;
    logic    overflow;
    flagsT   flags;
    flaggedT nextFlagged;

    rippleCarryAdderSubtractor #(
        .width(wordWidth)
    ) u_compare (
        .a        (request.rs1Value),
        .b        (request.rs2Value),
        .subtract (1'b1),
        .sum      (difference),
        .carryOut (carryOut),
        .overflow (overflow)
    );

    always_comb begin
        flags               = '0;
        flags[flagZero]     = (difference == '0);
        flags[flagCarry]    = ~carryOut; // no carry out means a borrow
        flags[flagNegative] = difference[wordWidth-1];
        flags[flagOverflow] = overflow;
    end

    always_comb begin
        nextFlagged.instClass = request.instClass;
        nextFlagged.funct3    = request.funct3;
        nextFlagged.imm       = request.imm;
        nextFlagged.rs1Value  = request.rs1Value; // jalr base
        nextFlagged.pc        = request.pc;
        nextFlagged.flags     = flags;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            flaggedValid <= 1'b0;
        end else begin
            flaggedValid <= inValid;
        end
    end

    always_ff @(posedge clk) begin
        flagged <= nextFlagged;
    end

endmodule

`default_nettype wire

//--- source/branchResolveStage.sv
// stage two: resolve the branch condition and pick base and offset for the target add
`default_nettype none

module branchResolveStage
    import rvIsaPkg::*;
    import pcPathPkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        flaggedValid,
    input  flaggedT     flagged,
    output logic        operandValid,
    output operandPairT operands
);

    logic        branchTaken;
    logic        isJump;
    logic        redirect;
    logic        signedLess;
    operandPairT nextOperands;

    assign signedLess = flagged.flags[flagNegative] ^ flagged.flags[flagOverflow];

    always_comb begin
        branchTaken = 1'b0;
        if (flagged.instClass == classBranch) begin
            case (branchFunctT'(flagged.funct3))
                branchBeq:  branchTaken = flagged.flags[flagZero];
                branchBne:  branchTaken = ~flagged.flags[flagZero];
                branchBlt:  branchTaken = signedLess;
                branchBge:  branchTaken = ~signedLess;
                branchBltu: branchTaken = flagged.flags[flagCarry];
                branchBgeu: branchTaken = ~flagged.flags[flagCarry];
                default:    branchTaken = 1'b0; // reserved funct3 falls through
            endcase
        end
    end

    assign isJump   = (flagged.instClass == classJal) || (flagged.instClass == classJalr);
    assign redirect = isJump | branchTaken;

    always_comb begin
        if (flagged.instClass == classJalr) begin
            nextOperands.base = flagged.rs1Value;
        end else begin
            nextOperands.base = flagged.pc;
        end

        // auipc stays sequential here, its result goes to the ALU
        if (redirect) begin
            nextOperands.offset = flagged.imm;
        end else begin
            nextOperands.offset = wordBytes;
        end
        nextOperands.redirect = redirect;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            operandValid <= 1'b0;
        end else begin
            operandValid <= flaggedValid;
        end
    end

    always_ff @(posedge clk) begin
        operands <= nextOperands;
    end

endmodule

`default_nettype wire

//--- source/targetAddStage.sv
// stage three: add base and offset, word-align the sum and register the next PC
`default_nettype none

module targetAddStage
    import pcPathPkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        operandValid,
    input  operandPairT operands,
    output logic        outValid,
    output pcResultT    result
);

    wordT     targetSum;
    pcResultT nextResult;

    rippleCarryAdderSubtractor #(
        .width(wordWidth)
    ) u_target (
        .a        (operands.base),
        .b        (operands.offset),
        .subtract (1'b0),
        .sum      (targetSum),
        .carryOut (),
        .overflow () // address wraps silently
    );

    always_comb begin
        nextResult.nextPc   = {targetSum[wordWidth-1:2], 2'b00}; // no compressed, word aligned
        nextResult.redirect = operands.redirect;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            outValid <= 1'b0;
        end else begin
            outValid <= operandValid;
        end
    end

    always_ff @(posedge clk) begin
        result <= nextResult;
    end

endmodule

`default_nettype wire

//--- source/pcUpdater.sv
// next-PC pipeline top: flag compare, branch resolve and target add, three cycles end to end
`default_nettype none

module pcUpdater
    import pcPathPkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      inValid,
    input  pcRequestT request,
    output logic      outValid,
    output pcResultT  result
);

    logic        flaggedValid;
    flaggedT     flagged;
    logic        operandValid;
    operandPairT operands;

    flagCompareStage u_flagCompare (
        .clk          (clk),
        .reset        (reset),
        .inValid      (inValid),
        .request      (request),
        .flaggedValid (flaggedValid),
        .flagged      (flagged)
    );

    branchResolveStage u_branchResolve (
        .clk          (clk),
        .reset        (reset),
        .flaggedValid (flaggedValid),
        .flagged      (flagged),
        .operandValid (operandValid),
        .operands     (operands)
    );

    targetAddStage u_targetAdd (
        .clk          (clk),
        .reset        (reset),
        .operandValid (operandValid),
        .operands     (operands),
        .outValid     (outValid),
        .result       (result)
    );

endmodule

`default_nettype wire

//--- sim/pcUpdaterTb.sv
// testbench for the next-PC pipeline: random requests checked against a reference model
`default_nettype none

module pcUpdaterTb
    import rvIsaPkg::*;
    import pcPathPkg::*;
();

    localparam int issueCycles  = 2000;
    localparam int resetCycles  = 10;
    localparam int marginCycles = 20;
    localparam int cycleLimit   = issueCycles + resetCycles + marginCycles;

    logic      clk;
    logic      reset;
    logic      inValid;
    pcRequestT request;
    logic      outValid;
    pcResultT  result;

    integer seed           = 57157;
    int     negCount       = 0; // advanced on falling edges only
    int     checkedCount   = 0;
    int     valueErrors    = 0;
    int     timingErrors   = 0;
    int     protocolErrors = 0;

    // scoreboard, one entry per accepted request
    pcResultT expectQ[$];
    int       dueQ[$];
    string    nameQ[$];

    pcUpdater u_dut (
        .clk      (clk),
        .reset    (reset),
        .inValid  (inValid),
        .request  (request),
        .outValid (outValid),
        .result   (result)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic wordT randomWord();
        return $random(seed);
    endfunction

    function automatic pcRequestT randomRequest();
        pcRequestT req;
        wordT      pickWord;
        wordT      immWord;
        wordT      modeSel;
        wordT      nearSign;
        pickWord     = randomWord();
        immWord      = randomWord();
        req.funct3   = pickWord[6:4]; // reserved branch codes included
        req.pc       = randomWord(); // low bits left random, target gets aligned
        req.rs1Value = randomWord();
        req.rs2Value = randomWord();
        if (pickWord[3:0] < 4'd6) begin
            req.instClass = instClassT'(pickWord[3:0]); // load .. auipc
            req.imm       = immWord;
        end else if (pickWord[3:0] < 4'd12) begin
            req.instClass = classBranch;
            req.imm       = {{19{immWord[12]}}, immWord[12:0]};
        end else if (pickWord[3:0] < 4'd14) begin
            req.instClass = classJal;
            req.imm       = {{11{immWord[20]}}, immWord[20:0]};
        end else begin
            req.instClass = classJalr;
            req.imm       = {{20{immWord[11]}}, immWord[11:0]};
        end
        modeSel = randomWord() % 3;
        if (modeSel == 0) begin
            req.rs2Value = req.rs1Value; // equal pair
        end else if (modeSel == 1) begin
            nearSign     = randomWord(); // both sides of the sign boundary
            req.rs1Value = 32'h8000_0000 + {24'd0, nearSign[7:0]};
            req.rs2Value = 32'h7fff_ffff - {24'd0, nearSign[15:8]};
            if (nearSign[16]) begin
                {req.rs1Value, req.rs2Value} = {req.rs2Value, req.rs1Value};
            end
        end
        return req;
    endfunction

    // reference next PC from plain integer compares
    function automatic pcResultT modelNextPc(pcRequestT req);
        pcResultT model;
        logic     taken;
        wordT     target;
        taken = 1'b0;
        if (req.instClass == classBranch) begin
            case (branchFunctT'(req.funct3))
                branchBeq:  taken = (req.rs1Value == req.rs2Value);
                branchBne:  taken = (req.rs1Value != req.rs2Value);
                branchBlt:  taken = ($signed(req.rs1Value) < $signed(req.rs2Value));
                branchBge:  taken = ($signed(req.rs1Value) >= $signed(req.rs2Value));
                branchBltu: taken = (req.rs1Value < req.rs2Value);
                branchBgeu: taken = (req.rs1Value >= req.rs2Value);
                default:    taken = 1'b0;
            endcase
        end
        if (req.instClass == classJalr) begin
            target = req.rs1Value + req.imm;
        end else if (req.instClass == classJal || taken) begin
            target = req.pc + req.imm;
        end else begin
            target = req.pc + wordBytes;
        end
        model.nextPc   = target & ~wordT'(3);
        model.redirect = taken || req.instClass == classJal || req.instClass == classJalr;
        return model;
    endfunction

    function automatic string testName(pcRequestT req);
        return $sformatf("%s funct3 %0d", req.instClass.name(), req.funct3);
    endfunction

    initial begin
        pcRequestT nextRequest;
        logic      nextValid;
        reset   = 1'b1;
        inValid = 1'b0;
        request = '0;
        repeat (resetCycles) @(posedge clk);
        reset <= 1'b0;
        for (int issue = 0; issue < issueCycles; issue++) begin
            @(posedge clk);
            nextRequest = randomRequest();
            nextValid   = (randomWord() % 4) != 0;
            if (issue >= 1000 && issue < 1100) begin
                nextValid = 1'b1; // back-to-back burst
            end
            inValid <= nextValid;
            request <= nextRequest;
            if (nextValid) begin
                expectQ.push_back(modelNextPc(nextRequest));
                dueQ.push_back(negCount + 4); // three cycles after the drive cycle
                nameQ.push_back(testName(nextRequest));
            end
        end
        @(posedge clk);
        inValid <= 1'b0;
        while (expectQ.size() != 0) @(posedge clk);
        repeat (4) @(posedge clk); // catch stray outValid after the drain
        $display("%0d results checked, errors: %0d value, %0d timing, %0d protocol",
                 checkedCount, valueErrors, timingErrors, protocolErrors);
        if (valueErrors + timingErrors + protocolErrors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    // outputs are sampled on the falling edge, half a cycle after they settle
    always @(negedge clk) begin
        pcResultT expected;
        int       dueCycle;
        string    name;
        negCount = negCount + 1;
        if (negCount >= cycleLimit) begin
            $display("timeout: run still going after %0d cycles", cycleLimit);
            $display("FAIL: see errors above");
            $finish;
        end else if (outValid === 1'b1) begin
            if (expectQ.size() == 0) begin
                $display("outValid high at cycle %0d with no request in flight", negCount);
                protocolErrors++;
            end else begin
                expected = expectQ.pop_front();
                dueCycle = dueQ.pop_front();
                name     = nameQ.pop_front();
                checkedCount++;
                if (dueCycle != negCount) begin
                    $display("error %s latency: expected cycle %0d actual cycle %0d",
                             name, dueCycle, negCount);
                    timingErrors++;
                end
                if (result.nextPc !== expected.nextPc) begin
                    $display("error %s nextPc: expected %h actual %h",
                             name, expected.nextPc, result.nextPc);
                    valueErrors++;
                end
                if (result.redirect !== expected.redirect) begin
                    $display("error %s redirect: expected %b actual %b",
                             name, expected.redirect, result.redirect);
                    valueErrors++;
                end
            end
        end else if (outValid !== 1'b0) begin
            $display("outValid is unknown at cycle %0d", negCount);
            protocolErrors++;
        end else if (dueQ.size() != 0 && dueQ[0] <= negCount) begin
            $display("no result for %s by cycle %0d", nameQ[0], dueQ[0]);
            protocolErrors++;
            void'(expectQ.pop_front());
            void'(dueQ.pop_front());
            void'(nameQ.pop_front());
        end
    end

endmodule

`default_nettype wire

//--- compile.f
source/rvIsaPkg.sv
source/pcPathPkg.sv
source/rippleCarryAdderSubtractor.sv
source/flagCompareStage.sv
source/branchResolveStage.sv
source/targetAddStage.sv
source/pcUpdater.sv
sim/pcUpdaterTb.sv

//--- Makefile
# Verilator flow for the next-PC pipeline: lint, simulate, clean

VERILATOR ?= verilator
FILELIST  ?= compile.f
TOP       ?= pcUpdaterTb
RTL_TOP   ?= pcUpdater
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing

FAIL_MSG = FAIL: see errors above

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

# the log decides the result, a crash also fails through the exit status
sim: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); exit $$status
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
